/* verilog/streamBridge_settings.svh */
`ifndef STREAMBRIDGE_SETTINGS_SVH
`define STREAMBRIDGE_SETTINGS_SVH

// width of one data word.
`define WORD_SIZE 8

// memory entries in the elastic buffer, a power of two.
// one entry stays unused, so the usable capacity is one less.
`define BUFFER_DEPTH 16

// fill level and credit counter width.
// one bit wider than the buffer address.
`define LEVEL_WIDTH ($clog2(`BUFFER_DEPTH) + 1)

`endif

/* verilog/streamBridgePkg.sv */
`include "streamBridge_settings.svh"

package streamBridgePkg;

	// one word on the stream, with its end-of-packet marker.
	typedef struct packed {
		logic [`WORD_SIZE-1:0] data;
		logic last; // final word of a packet.
	} streamBeat;

	// buffer state seen by the control and the outside world.
	typedef struct packed {
		logic isData; // at least one word stored.
		logic bufferFull; // next write would be dropped.
		logic dataLost; // last write attempt was dropped.
		logic [`LEVEL_WIDTH-1:0] level; // words currently stored.
	} bridgeStatus;

endpackage

/* verilog/fifoBuffer.sv */
`timescale 1ns/1ps
`include "streamBridge_settings.svh"

module fifoBuffer (
	input logic clk,
	input logic rst,
	input streamBridgePkg::streamBeat wrBeat,
	input logic wrEn,
	input logic pop,
	output streamBridgePkg::streamBeat headBeat,
	output streamBridgePkg::bridgeStatus status
);

	localparam int addressSize = $clog2(`BUFFER_DEPTH);
	localparam int levelWidth = `LEVEL_WIDTH;

	logic [addressSize-1:0] startPointer; // oldest stored word.
	logic [addressSize-1:0] endPointer; // next free slot.
	logic [addressSize-1:0] nextStartPointer;
	logic [addressSize-1:0] nextEndPointer;
	logic [addressSize-1:0] fillCount;

	streamBridgePkg::streamBeat mem [0:`BUFFER_DEPTH-1];

	logic isData;
	logic bufferFull;
	logic doWrite;
	logic doRead;
	logic lastWriteLostData;

	assign nextStartPointer = startPointer + 1'b1;
	assign nextEndPointer = endPointer + 1'b1;

	// full keeps one slot free so full and empty stay distinct.
	assign isData = startPointer != endPointer;
	assign bufferFull = nextEndPointer == startPointer;

	assign doWrite = wrEn && !bufferFull;
	assign doRead = pop && isData; // pop on empty is ignored.

	// pointer difference wraps modulo depth.
	assign fillCount = endPointer - startPointer;

	always_ff @(posedge clk) begin
		if (doWrite) begin
			mem[endPointer] <= wrBeat;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			startPointer <= '0;
			endPointer <= '0;
			lastWriteLostData <= 1'b0;
		end else begin
			if (doRead) begin
				startPointer <= nextStartPointer;
			end
			if (wrEn) begin
				endPointer <= doWrite ? nextEndPointer : endPointer;
				lastWriteLostData <= bufferFull; // set on drop, cleared on a good write.
			end
		end
	end

	// show-ahead head word.
	assign headBeat = mem[startPointer];

	assign status.isData = isData;
	assign status.bufferFull = bufferFull;
	assign status.dataLost = lastWriteLostData;
	assign status.level = levelWidth'(fillCount);

endmodule

/* verilog/ingressPort.sv */
`timescale 1ns/1ps

module ingressPort (
	input logic clk,
	input logic rst,
	input streamBridgePkg::streamBeat inBeat,
	input logic inValid,
	output streamBridgePkg::streamBeat wrBeat,
	output logic wrEn
);

	streamBridgePkg::streamBeat beatReg; // captured payload.
	logic validReg;

	// payload captured on each valid beat.
	always_ff @(posedge clk) begin
		if (inValid) begin
			beatReg <= inBeat;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			validReg <= 1'b0;
		end else begin
			validReg <= inValid; // every valid beat is accepted.
		end
	end

	// write request lasts exactly the cycle after sampling.
	assign wrBeat = beatReg;
	assign wrEn = validReg;

endmodule

/* verilog/egressPort.sv */
`timescale 1ns/1ps
`include "streamBridge_settings.svh"

module egressPort (
	input logic clk,
	input logic rst,
	input streamBridgePkg::streamBeat headBeat,
	input logic load,
	input logic creditIn,
	output streamBridgePkg::streamBeat outBeat,
	output logic outValid,
	output logic hasCredit
);

	localparam int creditWidth = `LEVEL_WIDTH;

	logic [creditWidth-1:0] creditCount; // downstream credits held.
	logic creditSaturated;
	streamBridgePkg::streamBeat beatReg;
	logic validReg;

	assign creditSaturated = &creditCount;
	assign hasCredit = creditCount != '0;

	// grant and spend in one cycle cancel out.
	always_ff @(posedge clk) begin
		if (rst) begin
			creditCount <= '0;
		end else begin
			if (creditIn && !load && !creditSaturated) begin
				creditCount <= creditCount + 1'b1;
			end else if (load && !creditIn) begin
				creditCount <= creditCount - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			beatReg <= headBeat; // head word taken at the pop edge.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			validReg <= 1'b0;
		end else begin
			validReg <= load; // one cycle per word.
		end
	end

	assign outBeat = beatReg;
	assign outValid = validReg;

endmodule

/* verilog/bridgeControl.sv */
`timescale 1ns/1ps

module bridgeControl (
	input logic clk,
	input logic rst,
	input streamBridgePkg::bridgeStatus status,
	input logic hasCredit,
	output logic pop,
	output logic load,
	output logic creditOut
);

	logic moveWord; // a word leaves the buffer this cycle.

	// one word moves when one is waiting and the receiver can take it.
	assign moveWord = status.isData && hasCredit;

	assign pop = moveWord;
	assign load = moveWord;

	// the freed slot goes back to the sender right away.
	assign creditOut = moveWord;

endmodule

/* verilog/streamBridge.sv */
`timescale 1ns/1ps

module streamBridge (
	input logic clk,
	input logic rst,
	input streamBridgePkg::streamBeat inBeat,
	input logic inValid,
	input logic creditIn,
	output streamBridgePkg::streamBeat outBeat,
	output logic outValid,
	output logic creditOut,
	output streamBridgePkg::bridgeStatus status
);

	streamBridgePkg::streamBeat wrBeat;
	streamBridgePkg::streamBeat headBeat;
	logic wrEn;
	logic pop;
	logic load;
	logic hasCredit;

	ingressPort i_ingressPort (
		.clk(clk),
		.rst(rst),
		.inBeat(inBeat),
		.inValid(inValid),
		.wrBeat(wrBeat),
		.wrEn(wrEn)
	);

	// elastic store between the two credit loops.
	fifoBuffer i_fifoBuffer (
		.clk(clk),
		.rst(rst),
		.wrBeat(wrBeat),
		.wrEn(wrEn),
		.pop(pop),
		.headBeat(headBeat),
		.status(status)
	);

	bridgeControl i_bridgeControl (
		.clk(clk),
		.rst(rst),
		.status(status),
		.hasCredit(hasCredit),
		.pop(pop),
		.load(load),
		.creditOut(creditOut)
	);

	egressPort i_egressPort (
		.clk(clk),
		.rst(rst),
		.headBeat(headBeat),
		.load(load),
		.creditIn(creditIn),
		.outBeat(outBeat),
		.outValid(outValid),
		.hasCredit(hasCredit)
	);

endmodule

/* verification/streamBridgeTests.svh */
task automatic finishTest(input string name, input int errorsAtStart);
	if (errorCount == errorsAtStart) begin
		testsPassed++;
		$display("test %s passed", name);
	end else begin
		testsFailed++;
		$display("test %s failed with %0d errors", name, errorCount - errorsAtStart);
	end
endtask

// one beat for one cycle from one falling edge to the next.
task automatic driveBeat(input streamBridgePkg::streamBeat beat, input bit stored);
	inBeat = beat;
	inValid = 1'b1;
	if (stored) begin
		scoreboard.push_back(beat);
		sentCount++;
	end
	@(negedge clk);
	inValid = 1'b0;
endtask

task automatic grantCredits(input int count);
	repeat (count) begin
		creditIn = 1'b1;
		@(negedge clk);
	end
	creditIn = 1'b0;
endtask

task automatic waitForDrain(input int maxCycles);
	int waited;
	waited = 0;
	while (scoreboard.size() != 0 && waited < maxCycles) begin
		@(negedge clk);
		waited++;
	end
	if (scoreboard.size() != 0) begin
		reportFailure($sformatf("%0d words never came out", scoreboard.size()));
	end
endtask

task automatic testResetState();
	int errorsAtStart;
	errorsAtStart = errorCount;
	checkValue("outValid", 32'(outValid), 0);
	checkValue("creditOut", 32'(creditOut), 0);
	checkValue("status.level", 32'(status.level), 0);
	checkValue("status.isData", 32'(status.isData), 0);
	checkValue("status.bufferFull", 32'(status.bufferFull), 0);
	checkValue("status.dataLost", 32'(status.dataLost), 0);
	finishTest("reset state", errorsAtStart);
endtask

task automatic testSinglePassThrough();
	int errorsAtStart;
	int outStart;
	int creditStart;
	int waited;
	errorsAtStart = errorCount;
	outStart = outCount;
	creditStart = creditOutCount;
	grantCredits(1);
	driveBeat(makeBeat(8'hA5, 1'b1), 1'b1);
	waited = 0; // falling edges since the sampling edge.
	while (!outValid && waited < 10) begin
		@(negedge clk);
		waited++;
	end
	checkValue("latency", waited, 2);
	repeat (4) @(negedge clk);
	checkValue("outValid count", outCount - outStart, 1);
	checkValue("creditOut count", creditOutCount - creditStart, 1);
	finishTest("single pass-through", errorsAtStart);
endtask

task automatic testFillAndOverrun();
	int errorsAtStart;
	int outStart;
	int creditStart;
	errorsAtStart = errorCount;
	outStart = outCount;
	creditStart = creditOutCount;
	checkValue("upstream credits", availableCredits(), capacity);
	for (int i = 0; i < capacity; i++) begin
		driveBeat(makeBeat(wordSize'(32'h40 + i), i[0]), 1'b1);
	end
	repeat (2) @(negedge clk);
	checkValue("status.bufferFull", 32'(status.bufferFull), 1);
	checkValue("status.isData", 32'(status.isData), 1);
	checkValue("status.level", 32'(status.level), capacity);
	checkValue("outValid count", outCount - outStart, 0);
	checkValue("creditOut count", creditOutCount - creditStart, 0);
	driveBeat(makeBeat(8'hEE, 1'b1), 1'b0); // beyond the credit limit so it gets dropped.
	@(negedge clk);
	checkValue("status.dataLost", 32'(status.dataLost), 1);
	checkValue("status.level", 32'(status.level), capacity);
	grantCredits(capacity);
	waitForDrain(40);
	repeat (2) @(negedge clk);
	checkValue("outValid count", outCount - outStart, capacity);
	checkValue("creditOut count", creditOutCount - creditStart, capacity);
	checkValue("status.level", 32'(status.level), 0);
	checkValue("status.isData", 32'(status.isData), 0);
	checkValue("status.bufferFull", 32'(status.bufferFull), 0);
	finishTest("fill and overrun", errorsAtStart);
endtask

task automatic testLostFlagClearing();
	int errorsAtStart;
	errorsAtStart = errorCount;
	checkValue("status.dataLost", 32'(status.dataLost), 1);
	grantCredits(1);
	driveBeat(makeBeat(8'h3C, 1'b0), 1'b1);
	@(negedge clk);
	checkValue("status.dataLost", 32'(status.dataLost), 0);
	waitForDrain(20);
	finishTest("lost flag clearing", errorsAtStart);
endtask

task automatic testBackPressure();
	int errorsAtStart;
	int outStart;
	int waited;
	int gap;
	errorsAtStart = errorCount;
	outStart = outCount;
	fork
		for (int sendIndex = 0; sendIndex < 40; sendIndex++) begin
			waited = 0;
			while (availableCredits() == 0 && waited < 200) begin
				@(negedge clk);
				waited++;
			end
			if (availableCredits() == 0) begin
				reportFailure("sender waited too long for an upstream credit");
			end else begin
				driveBeat(makeBeat(wordSize'(32'h80 + sendIndex), sendIndex % 8 == 7), 1'b1);
			end
		end
		for (int grantIndex = 0; grantIndex < 40; grantIndex++) begin
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) @(negedge clk);
			grantCredits(1);
		end
	join
	waitForDrain(60);
	repeat (2) @(negedge clk);
	checkValue("outValid count", outCount - outStart, 40);
	checkValue("status.level", 32'(status.level), 0);
	checkValue("status.dataLost", 32'(status.dataLost), 0);
	finishTest("back-pressure", errorsAtStart);
endtask

task automatic testRandomTraffic();
	int errorsAtStart;
	int outStart;
	int creditStart;
	int waited;
	streamBridgePkg::streamBeat beat;
	errorsAtStart = errorCount;
	outStart = outCount;
	creditStart = creditOutCount;
	for (int cycle = 0; cycle < 200; cycle++) begin
		inValid = 1'b0;
		if (($random(seed) & 1) != 0 && availableCredits() > 0) begin
			beat = makeBeat(wordSize'($random(seed)), 1'($random(seed)));
			inBeat = beat;
			inValid = 1'b1;
			scoreboard.push_back(beat);
			sentCount++;
		end
		// keeps the egress credit counter well below saturation.
		creditIn = ($random(seed) & 1) != 0 && (grantTotal - outCount) < 20;
		@(negedge clk);
	end
	inValid = 1'b0;
	waited = 0;
	while (scoreboard.size() != 0 && waited < 300) begin
		creditIn = (grantTotal - outCount) < scoreboard.size(); // credits only for stored words.
		@(negedge clk);
		waited++;
	end
	creditIn = 1'b0;
	if (scoreboard.size() != 0) begin
		reportFailure($sformatf("%0d words never came out after the drain", scoreboard.size()));
	end
	repeat (3) @(negedge clk);
	checkValue("creditOut count", creditOutCount - creditStart, outCount - outStart);
	checkValue("upstream credits", availableCredits(), capacity);
	checkValue("status.level", 32'(status.level), 0);
	finishTest("random traffic", errorsAtStart);
endtask

/* verification/streamBridgeTb.sv */
`timescale 1ns/1ps
`include "streamBridge_settings.svh"

module streamBridgeTb;

	localparam int clockPeriod = 8;
	localparam int resetCycles = 10;
	localparam int capacity = `BUFFER_DEPTH - 1;
	localparam int wordSize = `WORD_SIZE;
	// cycle budget of each test, in run order.
	localparam int testCycles = 20 + 20 + 90 + 30 + 400 + 550;
	localparam int watchdogCycles = 2 * (resetCycles + testCycles);

	logic clk = 1'b0;
	logic rst;
	streamBridgePkg::streamBeat inBeat;
	logic inValid;
	logic creditIn;
	streamBridgePkg::streamBeat outBeat;
	logic outValid;
	logic creditOut;
	streamBridgePkg::bridgeStatus status;

	streamBridgePkg::streamBeat scoreboard[$]; // sent but not yet delivered.
	streamBridgePkg::streamBeat expectedBeat;
	integer seed = 32'h3201bb85;
	int errorCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int sentCount = 0; // words that took an upstream credit.
	int outCount = 0;
	int creditOutCount = 0;
	int grantTotal = 0; // downstream credits granted.

	streamBridge i_streamBridge (
		.clk(clk),
		.rst(rst),
		.inBeat(inBeat),
		.inValid(inValid),
		.creditIn(creditIn),
		.outBeat(outBeat),
		.outValid(outValid),
		.creditOut(creditOut),
		.status(status)
	);

	always #(clockPeriod / 2) clk = ~clk;

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		errorCount++;
	endtask

	function automatic int availableCredits();
		return capacity - sentCount + creditOutCount;
	endfunction

	function automatic streamBridgePkg::streamBeat makeBeat(input logic [wordSize-1:0] data,
		input logic last);
		streamBridgePkg::streamBeat beat;
		beat.data = data;
		beat.last = last;
		return beat;
	endfunction

	`include "streamBridgeTests.svh"

	// every delivered word must be the oldest one still owed.
	initial begin
		forever begin
			@(posedge clk);
			if (!rst) begin
				if (outValid) begin
					outCount++;
					if (outCount > grantTotal) begin
						reportFailure("more words delivered than downstream credits granted");
					end
					if (scoreboard.size() == 0) begin
						reportFailure("a word was delivered that was never sent");
					end else begin
						expectedBeat = scoreboard.pop_front();
						checkValue("outBeat.data", 32'(outBeat.data), 32'(expectedBeat.data));
						checkValue("outBeat.last", 32'(outBeat.last), 32'(expectedBeat.last));
					end
				end
				creditOutCount += int'(creditOut);
				grantTotal += int'(creditIn); // a grant only counts from the next cycle.
			end
		end
	end

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("timeout: tests did not finish within %0d cycles", watchdogCycles);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		inBeat = '0;
		inValid = 1'b0;
		creditIn = 1'b0;
		repeat (resetCycles) @(negedge clk);
		rst = 1'b0;
		testResetState();
		testSinglePassThrough();
		testFillAndOverrun();
		testLostFlagClearing();
		testBackPressure();
		testRandomTraffic();
		repeat (2) @(negedge clk);
		$display("tests passed: %0d, tests failed: %0d, errors: %0d",
			testsPassed, testsFailed, errorCount);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* streamBridge.f */
+incdir+verilog
+incdir+verification
verilog/streamBridgePkg.sv
verilog/fifoBuffer.sv
verilog/ingressPort.sv
verilog/egressPort.sv
verilog/bridgeControl.sv
verilog/streamBridge.sv
verification/streamBridgeTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timescale 1ns/1ps -f streamBridge.f \
	--top-module streamBridgeTb -Mdir "$BUILD_DIR" -o streamBridgeSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/streamBridgeSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG_FILE"; then
	exit 1
fi
exit 0
